// ==== flist.f ====
src/sq_pkg.sv
src/sync_fifo.sv
src/host_pipes.sv
src/stream_mover.sv
src/cmd_block.sv
src/layer_engine.sv
src/squeeze_host_top.sv
verif/tb_squeeze_host.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_squeeze_host -f flist.f -Mdir obj_dir; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_squeeze_host 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
	exit 0
fi
exit 1

// ==== verif/tb_squeeze_host.sv ====
`default_nettype none

module tb_squeeze_host;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int FIFO_DEPTH      = 64;
	localparam int BLOCK_SIZE      = 8;
	localparam int BUFFER_HEADROOM = 4;
	localparam int WAIT_LIMIT      = 200;	// cycles per wait loop
	localparam int QUIET_CYCLES    = 40;	// window for dropped commands
	localparam int NUM_ROWS        = 8;

	typedef struct packed {
		logic        neg_data;	// all data halves negative
		logic [2:0]  op_code;	// raw cmd[31:29]
		logic [15:0] op_num;
		logic        exp_irq;
		logic        exp_result;
	} op_row_t;

	logic          okClk;
	logic          rst_n;
	logic          pipe_in_write;
	sq_pkg::word_t pipe_in_data;
	logic          pipe_out_read;
	sq_pkg::word_t pipe_out_data;
	logic          op_en;
	logic          pipe_in_ready;
	logic          pipe_out_ready;
	logic          irq;
	logic [7:0]    led;

	integer        seed;
	int            mismatch_count;
	int            failure_count;
	op_row_t       rows [NUM_ROWS];
	sq_pkg::word_t sent [$];	// loopback words in order
	sq_pkg::word_t packed_words [$];	// data and weight of the current row

	squeeze_host_top #(
		.FIFO_DEPTH      (FIFO_DEPTH),
		.BLOCK_SIZE      (BLOCK_SIZE),
		.BUFFER_HEADROOM (BUFFER_HEADROOM)
	) u_dut (
		.okClk (okClk), .rst_n (rst_n),
		.pipe_in_write (pipe_in_write), .pipe_in_data (pipe_in_data),
		.pipe_out_read (pipe_out_read), .pipe_out_data (pipe_out_data),
		.op_en (op_en), .pipe_in_ready (pipe_in_ready), .pipe_out_ready (pipe_out_ready),
		.irq (irq), .led (led)
	);

	always #5 okClk = ~okClk;

	// ------------------------------------------------------------
	// bus and wait helpers
	// ------------------------------------------------------------
	task automatic tick();
		@(posedge okClk);
		#1;	// inputs change just after the edge
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (8) tick();
		rst_n = 1'b1;
	endtask

	task automatic report_mismatch(input string msg);
		mismatch_count++;
		$display("mismatch at %0.1f ns: %s", $realtime, msg);
	endtask

	task automatic report_failure(input string msg);
		failure_count++;
		$display("error at %0.1f ns: %s", $realtime, msg);
	endtask

	task automatic write_word(input sq_pkg::word_t w);
		pipe_in_write = 1'b1;
		pipe_in_data  = w;
		tick();
		pipe_in_write = 1'b0;
	endtask

	task automatic wait_led_on(input int idx, output logic found);
		int n;
		found = 1'b0;
		for (n = 0; n < WAIT_LIMIT && !found; n++) begin
			if (!led[idx]) found = 1'b1;	// lights are active low
			else tick();
		end
	endtask

	task automatic read_word(output sq_pkg::word_t w);
		logic found;
		int   n;
		found = 1'b0;
		for (n = 0; n < WAIT_LIMIT && !found; n++) begin
			if (led[sq_pkg::LED_PIPE_OUT_EMPTY]) found = 1'b1;	// empty light off
			else tick();
		end
		assert (found) else report_failure("pipe-out stayed empty while a word was expected");
		w = pipe_out_data;
		if (found) begin
			pipe_out_read = 1'b1;
			tick();
			pipe_out_read = 1'b0;
		end
	endtask

	// conv wraps at 32 bits, maxpool keeps the signed maximum of the data halves
	function automatic sq_pkg::word_t expected_result(input logic [2:0] code);
		logic signed [15:0] d;
		logic signed [15:0] wt;
		logic signed [31:0] acc;
		logic signed [31:0] prod;
		int                 i;
		acc = (code == sq_pkg::OP_MAXPOOL) ? -32'sd32768 : 32'sd0;
		for (i = 0; i < packed_words.size(); i++) begin
			d    = packed_words[i][31:16];
			wt   = packed_words[i][15:0];
			prod = 32'(d) * 32'(wt);
			if (code == sq_pkg::OP_MAXPOOL) begin
				if (32'(d) > acc) acc = 32'(d);
			end else begin
				acc = acc + prod;
			end
		end
		return acc;
	endfunction

	// ------------------------------------------------------------
	// scenarios
	// ------------------------------------------------------------
	task automatic check_loopback();
		sq_pkg::word_t w;
		logic          seen;
		int            i;
		op_en = 1'b0;
		sent.delete();
		for (i = 0; i < 16; i++) begin
			w = $random(seed);
			sent.push_back(w);
			write_word(w);
		end
		seen = 1'b0;
		for (i = 0; i < WAIT_LIMIT && !seen; i++) begin
			if (pipe_out_ready) seen = 1'b1;
			else tick();
		end
		assert (seen) else report_failure("pipe_out_ready did not rise with a block waiting");
		for (i = 0; i < 16; i++) begin
			read_word(w);
			assert (w == sent[i]) else
				report_mismatch($sformatf("loopback word %0d is %h, expected %h", i, w, sent[i]));
			if (i == 7) begin
				assert (pipe_out_ready) else
					report_mismatch("pipe_out_ready low with 8 words unread");
			end
			if (i == 9) begin
				assert (!pipe_out_ready) else
					report_mismatch("pipe_out_ready high with fewer than 8 words unread");
			end
		end
	endtask

	task automatic check_throttle();
		int written;
		written = 0;
		op_en   = 1'b0;
		while (pipe_in_ready && written < 120) begin
			write_word($random(seed));
			written++;
			assert (led[sq_pkg::LED_PIPE_OUT_FULL]) else
				report_failure("pipe-out filled past the mover limit");
		end
		assert (!pipe_in_ready) else report_failure("pipe_in_ready never fell with pipe-out unread");
		// 60 or 61 words held in pipe-out, 52 or 53 in pipe-in
		assert (written >= 112 && written <= 116) else
			report_mismatch($sformatf("pipe_in_ready fell after %0d writes", written));
		// both pipes partly filled, no light on
		assert (led == 8'b1111_1111) else
			report_mismatch($sformatf("lights %b with both pipes partly filled", led));
	endtask

	task automatic run_row(input int r);
		op_row_t       row;
		sq_pkg::word_t w;
		sq_pkg::word_t expected;
		logic          found;
		logic          seen_run;
		logic          seen_irq;
		logic          seen_word;
		int            i;
		row = rows[r];
		write_word({row.op_code, 13'd0, row.op_num});	// command word
		if (row.exp_irq) begin
			wait_led_on(sq_pkg::LED_OP_RUN, found);
			assert (found) else report_failure($sformatf("row %0d: operation never started", r));
			// both pipes empty, op_run and op_en lights on
			assert (led == 8'b1010_0011) else
				report_mismatch($sformatf("row %0d: lights %b at operation start", r, led));
			packed_words.delete();
			for (i = 0; i < int'(row.op_num); i++) begin
				w = $random(seed);
				if (row.neg_data) w[31] = 1'b1;
				packed_words.push_back(w);
				write_word(w);
			end
			expected = expected_result(row.op_code);
			found = 1'b0;
			for (i = 0; i < WAIT_LIMIT && !found; i++) begin
				if (irq) found = 1'b1;
				else tick();
			end
			assert (found) else report_failure($sformatf("row %0d: irq never pulsed", r));
			tick();
			assert (!irq) else report_failure($sformatf("row %0d: irq longer than one cycle", r));
			read_word(w);
			assert (w == expected) else
				report_mismatch($sformatf("row %0d result %h, expected %h", r, w, expected));
			assert (!led[sq_pkg::LED_PIPE_OUT_EMPTY]) else
				report_failure($sformatf("row %0d: extra words in pipe-out", r));
			assert (led[sq_pkg::LED_OP_RUN]) else
				report_failure($sformatf("row %0d: op_run still high after irq", r));
		end else begin
			seen_run  = 1'b0;
			seen_irq  = 1'b0;
			seen_word = 1'b0;
			for (i = 0; i < QUIET_CYCLES; i++) begin
				tick();
				if (!led[sq_pkg::LED_OP_RUN]) seen_run = 1'b1;
				if (irq) seen_irq = 1'b1;
				if (led[sq_pkg::LED_PIPE_OUT_EMPTY]) seen_word = 1'b1;
			end
			assert (!seen_run && !seen_irq) else
				report_failure($sformatf("row %0d: dropped command started an operation", r));
			assert (seen_word == row.exp_result) else
				report_failure($sformatf("row %0d: dropped command wrote to pipe-out", r));
		end
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		okClk          = 1'b0;
		rst_n          = 1'b0;
		pipe_in_write  = 1'b0;
		pipe_in_data   = '0;
		pipe_out_read  = 1'b0;
		op_en          = 1'b0;
		seed           = 73;
		mismatch_count = 0;
		failure_count  = 0;

		// neg, type, count, irq, result
		rows[0] = '{1'b0, sq_pkg::OP_CONV, 16'd5, 1'b1, 1'b1};
		rows[1] = '{1'b0, sq_pkg::OP_MAXPOOL, 16'd7, 1'b1, 1'b1};
		rows[2] = '{1'b1, sq_pkg::OP_MAXPOOL, 16'd4, 1'b1, 1'b1};
		rows[3] = '{1'b0, 3'd5, 16'd3, 1'b0, 1'b0};	// unknown type
		rows[4] = '{1'b0, sq_pkg::OP_CONV, 16'd0, 1'b0, 1'b0};	// zero count
		rows[5] = '{1'b0, sq_pkg::OP_CONV, 16'd6, 1'b1, 1'b1};
		rows[6] = '{1'b0, sq_pkg::OP_NONE, 16'd2, 1'b0, 1'b0};
		rows[7] = '{1'b1, sq_pkg::OP_CONV, 16'd12, 1'b1, 1'b1};

		apply_reset();
		assert (!pipe_in_ready && !pipe_out_ready && !irq) else
			report_failure("ready or irq high right after reset");
		// only the two empty lights on
		assert (led == 8'b1010_1111) else
			report_mismatch($sformatf("lights %b after reset", led));
		tick();
		assert (pipe_in_ready) else report_failure("pipe_in_ready low after reset");

		check_loopback();
		check_throttle();

		apply_reset();	// drop the words left by the throttle run
		op_en = 1'b1;
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end

		$display("errors: %0d mismatch, %0d other", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/squeeze_host_top.sv ====
`default_nettype none

module squeeze_host_top #(
	parameter int FIFO_DEPTH      = 1024,
	parameter int BLOCK_SIZE      = 128,	// 512 bytes per host block
	parameter int BUFFER_HEADROOM = 20
) (
	input  wire                okClk,
	input  wire                rst_n,
	input  wire                pipe_in_write,
	input  wire sq_pkg::word_t pipe_in_data,
	input  wire                pipe_out_read,
	output sq_pkg::word_t      pipe_out_data,
	input  wire                op_en,
	output logic               pipe_in_ready,
	output logic               pipe_out_ready,
	output logic               irq,
	output logic [7:0]         led
);

	// ------------------------------------------------------------
	// fabric wires
	// ------------------------------------------------------------
	sq_pkg::word_t    in_word;
	logic             in_empty;
	logic             in_pop;
	sq_pkg::count_t   out_count;
	logic             out_full;
	logic             out_push;
	logic             cmd_push;
	logic             data_push;
	sq_pkg::word_t    move_word;
	sq_pkg::count_t   cmd_count;
	sq_pkg::count_t   data_count;
	sq_pkg::word_t    cmd;
	logic             cmd_empty;
	logic             cmd_pop;
	sq_pkg::word_t    data_word;
	logic             data_empty;
	logic             data_pop;
	logic             op_start;
	sq_pkg::op_type_t op_type;
	sq_pkg::op_num_t  op_num;
	logic             op_run;
	logic             op_done;
	logic             result_push;
	sq_pkg::word_t    result_word;

	assign out_full = (out_count == sq_pkg::count_t'(FIFO_DEPTH));

	host_pipes #(
		.FIFO_DEPTH      (FIFO_DEPTH),
		.BLOCK_SIZE      (BLOCK_SIZE),
		.BUFFER_HEADROOM (BUFFER_HEADROOM)
	) u_host_pipes (
		.okClk (okClk), .rst_n (rst_n),
		.pipe_in_write (pipe_in_write), .pipe_in_data (pipe_in_data),
		.in_pop (in_pop), .in_word (in_word), .in_empty (in_empty),
		.out_push (out_push), .result_push (result_push),
		.out_word (move_word), .result_word (result_word),
		.out_count (out_count),
		.pipe_out_read (pipe_out_read), .pipe_out_data (pipe_out_data),
		.pipe_in_ready (pipe_in_ready), .pipe_out_ready (pipe_out_ready),
		.op_en (op_en), .op_run (op_run), .led (led)
	);

	stream_mover #(
		.FIFO_DEPTH      (FIFO_DEPTH),
		.BUFFER_HEADROOM (BUFFER_HEADROOM)
	) u_stream_mover (
		.okClk (okClk), .rst_n (rst_n),
		.op_en (op_en), .op_run (op_run),
		.in_empty (in_empty), .in_word (in_word), .in_pop (in_pop),
		.out_count (out_count), .cmd_count (cmd_count), .data_count (data_count),
		.out_push (out_push), .cmd_push (cmd_push), .data_push (data_push),
		.move_word (move_word)
	);

	sync_fifo #(.DEPTH(FIFO_DEPTH)) u_cmd_fifo (
		.okClk (okClk), .rst_n (rst_n),
		.wr_en (cmd_push), .rd_en (cmd_pop), .din (move_word), .dout (cmd),
		.empty (cmd_empty), .full (), .count (cmd_count)
	);

	sync_fifo #(.DEPTH(FIFO_DEPTH)) u_data_fifo (	// packed data and weight
		.okClk (okClk), .rst_n (rst_n),
		.wr_en (data_push), .rd_en (data_pop), .din (move_word), .dout (data_word),
		.empty (data_empty), .full (), .count (data_count)
	);

	cmd_block u_cmd_block (
		.okClk (okClk), .rst_n (rst_n), .op_en (op_en),
		.cmd_empty (cmd_empty), .cmd (cmd), .cmd_pop (cmd_pop),
		.op_start (op_start), .op_type (op_type), .op_num (op_num),
		.op_run (op_run), .op_done (op_done), .irq (irq)
	);

	layer_engine u_layer_engine (
		.okClk (okClk), .rst_n (rst_n),
		.op_start (op_start), .op_type (op_type), .op_num (op_num),
		.data_empty (data_empty), .data_word (data_word), .data_pop (data_pop),
		.out_full (out_full),
		.result_push (result_push), .result_word (result_word),
		.op_done (op_done)
	);

endmodule

`default_nettype wire

// ==== src/layer_engine.sv ====
`default_nettype none

module layer_engine (
	input  wire                     okClk,
	input  wire                     rst_n,
	input  wire                     op_start,
	input  wire sq_pkg::op_type_t   op_type,
	input  wire sq_pkg::op_num_t    op_num,
	input  wire                     data_empty,
	input  wire sq_pkg::word_t      data_word,
	output logic                    data_pop,
	input  wire                     out_full,
	output logic                    result_push,
	output sq_pkg::word_t           result_word,
	output logic                    op_done
);

	localparam sq_pkg::word_t MAX_INIT = 32'hffff_8000;	// -32768, below any data

	logic               busy;
	sq_pkg::op_num_t    remain;	// words still to consume
	sq_pkg::word_t      acc;	// sum of products or running max
	sq_pkg::half_t      data_h;
	sq_pkg::half_t      weight_h;
	logic signed [31:0] prod;
	logic signed [31:0] data_ext;
	logic               is_pool;

	assign data_h   = data_word[31:16];
	assign weight_h = data_word[15:0];
	assign prod     = data_h * weight_h;	// full 32-bit signed product
	assign data_ext = data_h;	// sign extended
	assign is_pool  = (op_type == sq_pkg::OP_MAXPOOL);

	assign data_pop    = busy && (remain != '0) && !data_empty;
	assign result_push = busy && (remain == '0) && !out_full;
	assign op_done     = result_push;	// same cycle as the result write
	assign result_word = acc;

	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			busy   <= 1'b0;
			remain <= '0;
		end else if (op_start) begin
			busy   <= 1'b1;
			remain <= op_num;
		end else if (data_pop) begin
			remain <= remain - 1'b1;
		end else if (result_push) begin
			busy <= 1'b0;
		end
	end

	// ------------------------------------------------------------
	// accumulate, conv wraps at 32 bits
	// ------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (op_start) begin
			acc <= is_pool ? MAX_INIT : '0;
		end else if (data_pop) begin
			if (is_pool) begin
				if (data_ext > $signed(acc)) acc <= sq_pkg::word_t'(data_ext);
			end else begin
				acc <= acc + sq_pkg::word_t'(prod);
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/cmd_block.sv ====
`default_nettype none

module cmd_block (
	input  wire                okClk,
	input  wire                rst_n,
	input  wire                op_en,
	input  wire                cmd_empty,
	input  wire sq_pkg::word_t cmd,
	output logic               cmd_pop,
	output logic               op_start,
	output sq_pkg::op_type_t   op_type,
	output sq_pkg::op_num_t    op_num,
	output logic               op_run,
	input  wire                op_done,
	output logic               irq
);

	sq_pkg::csb_state_t state;
	sq_pkg::op_type_t   cmd_type;	// decoded from the head command
	sq_pkg::op_num_t    cmd_num;
	logic               cmd_ok;
	sq_pkg::op_type_t   type_q;	// held for the running operation
	sq_pkg::op_num_t    num_q;

	// ------------------------------------------------------------
	// decode
	// ------------------------------------------------------------
	assign cmd_type = sq_pkg::op_type_t'(cmd[31:29]);
	assign cmd_num  = cmd[15:0];

	always_comb begin
		case (cmd_type)
			sq_pkg::OP_CONV,
			sq_pkg::OP_MAXPOOL: cmd_ok = (cmd_num != '0);
			default:            cmd_ok = 1'b0;	// none or unknown type
		endcase
	end

	assign cmd_pop  = (state == sq_pkg::CSB_IDLE) && op_en && !cmd_empty;
	assign op_start = cmd_pop && cmd_ok;	// bad commands are just dropped

	// decoded values show in the fetch cycle, held values afterwards
	assign op_type = (state == sq_pkg::CSB_IDLE) ? cmd_type : type_q;
	assign op_num  = (state == sq_pkg::CSB_IDLE) ? cmd_num : num_q;

	assign op_run = (state == sq_pkg::CSB_RUN);
	assign irq    = (state == sq_pkg::CSB_DONE);	// one cycle wide

	// ------------------------------------------------------------
	// run state
	// ------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			state  <= sq_pkg::CSB_IDLE;
			type_q <= sq_pkg::OP_NONE;
			num_q  <= '0;
		end else begin
			case (state)
				sq_pkg::CSB_IDLE: begin
					if (op_start) begin
						state  <= sq_pkg::CSB_RUN;
						type_q <= cmd_type;
						num_q  <= cmd_num;
					end
				end
				sq_pkg::CSB_RUN: begin
					if (op_done) state <= sq_pkg::CSB_DONE;
				end
				sq_pkg::CSB_DONE: begin
					state <= sq_pkg::CSB_IDLE;
				end
				default: begin
					state <= sq_pkg::CSB_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/stream_mover.sv ====
`default_nettype none

module stream_mover #(
	parameter int FIFO_DEPTH      = 1024,
	parameter int BUFFER_HEADROOM = 20
) (
	input  wire                 okClk,
	input  wire                 rst_n,
	input  wire                 op_en,
	input  wire                 op_run,
	input  wire                 in_empty,
	input  wire sq_pkg::word_t  in_word,
	output logic                in_pop,
	input  wire sq_pkg::count_t out_count,
	input  wire sq_pkg::count_t cmd_count,
	input  wire sq_pkg::count_t data_count,
	output logic                out_push,
	output logic                cmd_push,
	output logic                data_push,
	output sq_pkg::word_t       move_word
);

	localparam sq_pkg::count_t DEST_LIMIT = sq_pkg::count_t'(FIFO_DEPTH - BUFFER_HEADROOM);

	// destination tags
	localparam logic [1:0] DST_OUT  = 2'd0;	// loopback to pipe-out
	localparam logic [1:0] DST_CMD  = 2'd1;
	localparam logic [1:0] DST_DATA = 2'd2;

	logic [1:0]     sel_dest;
	sq_pkg::count_t sel_count;
	logic           move_valid;	// one word in flight
	logic [1:0]     move_dest;

	// same routing as the output mux: op_en picks loopback or accelerator
	always_comb begin
		if (!op_en) begin
			sel_dest  = DST_OUT;
			sel_count = out_count;
		end else if (op_run) begin
			sel_dest  = DST_DATA;
			sel_count = data_count;
		end else begin
			sel_dest  = DST_CMD;
			sel_count = cmd_count;
		end
	end

	assign in_pop = !in_empty && (sel_count < DEST_LIMIT);	// stall at the limit

	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			move_valid <= 1'b0;
			move_dest  <= DST_OUT;
		end else begin
			move_valid <= in_pop;
			move_dest  <= sel_dest;
		end
	end

	always_ff @(posedge okClk) begin
		if (in_pop) move_word <= in_word;
	end

	// write lands one cycle after the pop, at one destination only
	assign out_push  = move_valid && (move_dest == DST_OUT);
	assign cmd_push  = move_valid && (move_dest == DST_CMD);
	assign data_push = move_valid && (move_dest == DST_DATA);

endmodule

`default_nettype wire

// ==== src/host_pipes.sv ====
`default_nettype none

module host_pipes #(
	parameter int FIFO_DEPTH      = 1024,
	parameter int BLOCK_SIZE      = 128,
	parameter int BUFFER_HEADROOM = 20
) (
	input  wire                okClk,
	input  wire                rst_n,
	input  wire                pipe_in_write,
	input  wire sq_pkg::word_t pipe_in_data,
	input  wire                in_pop,
	output sq_pkg::word_t      in_word,
	output logic               in_empty,
	input  wire                out_push,
	input  wire                result_push,
	input  wire sq_pkg::word_t out_word,
	input  wire sq_pkg::word_t result_word,
	output sq_pkg::count_t     out_count,
	input  wire                pipe_out_read,
	output sq_pkg::word_t      pipe_out_data,
	output logic               pipe_in_ready,
	output logic               pipe_out_ready,
	input  wire                op_en,
	input  wire                op_run,
	output logic [7:0]         led
);

	// room for one more block, less the headroom for count latency
	localparam sq_pkg::count_t IN_READY_MAX =
		sq_pkg::count_t'(FIFO_DEPTH - 1 - BUFFER_HEADROOM - BLOCK_SIZE);
	localparam sq_pkg::count_t OUT_READY_MIN = sq_pkg::count_t'(BLOCK_SIZE);

	sq_pkg::count_t in_count;
	logic           in_full;
	logic           out_full;
	logic           out_empty;
	logic           po_wr;	// merged pipe-out write
	sq_pkg::word_t  po_din;
	logic           held_valid;	// mover word deferred by a result
	sq_pkg::word_t  held_word;

	sync_fifo #(.DEPTH(FIFO_DEPTH)) u_pipe_in (
		.okClk (okClk),
		.rst_n (rst_n),
		.wr_en (pipe_in_write),
		.rd_en (in_pop),
		.din   (pipe_in_data),
		.dout  (in_word),
		.empty (in_empty),
		.full  (in_full),
		.count (in_count)
	);

	sync_fifo #(.DEPTH(FIFO_DEPTH)) u_pipe_out (
		.okClk (okClk),
		.rst_n (rst_n),
		.wr_en (po_wr),
		.rd_en (pipe_out_read),
		.din   (po_din),
		.dout  (pipe_out_data),
		.empty (out_empty),
		.full  (out_full),
		.count (out_count)
	);

	// ------------------------------------------------------------
	// pipe-out writers: result first, then held word, then mover
	// ------------------------------------------------------------
	always_comb begin
		if (result_push) begin
			po_wr  = 1'b1;
			po_din = result_word;
		end else if (held_valid) begin
			po_wr  = 1'b1;
			po_din = held_word;
		end else begin
			po_wr  = out_push;
			po_din = out_word;
		end
	end

	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			held_valid     <= 1'b0;
			pipe_in_ready  <= 1'b0;
			pipe_out_ready <= 1'b0;
		end else begin
			held_valid     <= out_push && (result_push || held_valid);
			pipe_in_ready  <= (in_count <= IN_READY_MAX);	// block throttle
			pipe_out_ready <= (out_count >= OUT_READY_MIN);	// a full block waits
		end
	end

	always_ff @(posedge okClk) begin
		if (out_push) held_word <= out_word;	// only read while held_valid
	end

	// status lights, low means on
	always_comb begin
		led                             = '1;
		led[sq_pkg::LED_PIPE_IN_FULL]   = ~in_full;
		led[sq_pkg::LED_PIPE_IN_EMPTY]  = ~in_empty;
		led[sq_pkg::LED_PIPE_OUT_FULL]  = ~out_full;
		led[sq_pkg::LED_PIPE_OUT_EMPTY] = ~out_empty;
		led[sq_pkg::LED_OP_RUN]         = ~op_run;
		led[sq_pkg::LED_OP_EN]          = ~op_en;
		led[sq_pkg::LED_SPARE_1]        = 1'b1;
		led[sq_pkg::LED_SPARE_0]        = 1'b1;
	end

endmodule

`default_nettype wire

// ==== src/sync_fifo.sv ====
`default_nettype none

module sync_fifo #(
	parameter int DEPTH = 1024
) (
	input  wire                okClk,
	input  wire                rst_n,
	input  wire                wr_en,
	input  wire                rd_en,
	input  wire sq_pkg::word_t din,
	output sq_pkg::word_t      dout,
	output logic               empty,
	output logic               full,
	output sq_pkg::count_t     count
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	sq_pkg::word_t mem [DEPTH];	// circular buffer
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic          do_wr;
	logic          do_rd;

	// pointers wrap at DEPTH, also for depths that are not a power of two
	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
		if (ptr == AW'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign do_wr = wr_en && !full;	// write when full is ignored
	assign do_rd = rd_en && !empty;	// read when empty is ignored
	assign empty = (count == '0);
	assign full  = (count == sq_pkg::count_t'(DEPTH));
	assign dout  = mem[rd_ptr];	// head word shows while not empty

	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) wr_ptr <= next_ptr(wr_ptr);
			if (do_rd) rd_ptr <= next_ptr(rd_ptr);
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

	always_ff @(posedge okClk) begin
		if (do_wr) mem[wr_ptr] <= din;
	end

endmodule

`default_nettype wire

// ==== src/sq_pkg.sv ====
`default_nettype none

package sq_pkg;

	// ------------------------------------------------------------
	// stream word and count widths
	// ------------------------------------------------------------
	typedef logic [31:0] word_t;	// one pipe word
	typedef logic [10:0] count_t;	// fifo occupancy, up to 1024 words
	typedef logic [15:0] op_num_t;	// words per operation, cmd[15:0]
	typedef logic signed [15:0] half_t;	// data in [31:16], weight in [15:0]

	// operation type from cmd[31:29]; other codes are rejected
	typedef enum logic [2:0] {
		OP_NONE    = 3'd0,
		OP_CONV    = 3'd1,
		OP_MAXPOOL = 3'd2
	} op_type_t;

	typedef enum logic [1:0] {
		CSB_IDLE,	// waiting for a command
		CSB_RUN,	// engine busy
		CSB_DONE	// one cycle, raises irq
	} csb_state_t;

	// ------------------------------------------------------------
	// status light positions, lights are active low
	// ------------------------------------------------------------
	localparam logic [2:0] LED_PIPE_IN_FULL   = 3'd7;
	localparam logic [2:0] LED_PIPE_IN_EMPTY  = 3'd6;
	localparam logic [2:0] LED_PIPE_OUT_FULL  = 3'd5;
	localparam logic [2:0] LED_PIPE_OUT_EMPTY = 3'd4;
	localparam logic [2:0] LED_OP_RUN         = 3'd3;
	localparam logic [2:0] LED_OP_EN          = 3'd2;
	localparam logic [2:0] LED_SPARE_1        = 3'd1;	// held off
	localparam logic [2:0] LED_SPARE_0        = 3'd0;	// held off

endpackage

`default_nettype wire
